//--- hw/vdec_pkg.sv
// vector decode package: RVV encodings, decoded operations and control field types
`default_nettype none

package vdec_pkg;

  localparam int INSTR_W   = 32;
  localparam int REG_IDX_W = 5;

  typedef enum logic [6:0] {
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111,
    VECTOR   = 7'b1010111
  } opcode_t;

  // funct3 of the VECTOR opcode; 001 and 101 are the float forms, not decoded here
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // OPI funct6
  localparam logic [5:0] VADD   = 6'b000000;
  localparam logic [5:0] VSUB   = 6'b000010;
  localparam logic [5:0] VRSUB  = 6'b000011;
  localparam logic [5:0] VMINU  = 6'b000100;
  localparam logic [5:0] VMIN   = 6'b000101;
  localparam logic [5:0] VMAXU  = 6'b000110;
  localparam logic [5:0] VMAX   = 6'b000111;
  localparam logic [5:0] VAND   = 6'b001001;
  localparam logic [5:0] VOR    = 6'b001010;
  localparam logic [5:0] VXOR   = 6'b001011;
  localparam logic [5:0] VMSEQ  = 6'b011000;
  localparam logic [5:0] VMSNE  = 6'b011001;
  localparam logic [5:0] VMSLTU = 6'b011010;
  localparam logic [5:0] VMSLT  = 6'b011011;
  localparam logic [5:0] VMSLEU = 6'b011100;
  localparam logic [5:0] VMSLE  = 6'b011101;
  localparam logic [5:0] VMSGTU = 6'b011110;
  localparam logic [5:0] VMSGT  = 6'b011111;
  localparam logic [5:0] VSLL   = 6'b100101;
  localparam logic [5:0] VSRL   = 6'b101000;
  localparam logic [5:0] VSRA   = 6'b101001;

  // OPM funct6, overlapping the OPI space
  localparam logic [5:0] VDIVU   = 6'b100000;
  localparam logic [5:0] VDIV    = 6'b100001;
  localparam logic [5:0] VREMU   = 6'b100010;
  localparam logic [5:0] VREM    = 6'b100011;
  localparam logic [5:0] VMULHU  = 6'b100100;
  localparam logic [5:0] VMUL    = 6'b100101;
  localparam logic [5:0] VMULHSU = 6'b100110;
  localparam logic [5:0] VMULH   = 6'b100111;
  localparam logic [5:0] VWADDU  = 6'b110000;
  localparam logic [5:0] VWADD   = 6'b110001;
  localparam logic [5:0] VWSUBU  = 6'b110010;
  localparam logic [5:0] VWSUB   = 6'b110011;

  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } mem_width_t;

  typedef enum logic [5:0] {
    BAD_OP,
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT, OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM,
    OP_VWADDU, OP_VWADD, OP_VWSUBU, OP_VWSUB
  } vop_t;

  typedef enum logic [2:0] {CLS_NONE, CLS_ARITH, CLS_CFG, CLS_LOAD, CLS_STORE} op_class_t;
  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfgsel_t;

  typedef enum logic [2:0] {ARITH, MUL, DIV, LOAD_UNIT, STORE_UNIT} fu_type_t;
  // ten ALU ops need a 4-bit code
  typedef enum logic [3:0] {SLL, SRL, SRA, ADD, SUB, AND, OR, XOR, COMP, MM} valu_op_t;
  typedef enum logic [2:0] {VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT} comp_type_t;
  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_type_t;
  typedef enum logic [1:0] {UNSIGNED, SIGNED, UNSIGNED_SIGNED, SIGNED_UNSIGNED} sign_mode_t;
  typedef enum logic [1:0] {V, X, I} src_type_t;

  typedef struct packed {
    logic                 illegal_insn;
    fu_type_t             fu_type;
    valu_op_t             alu_op;
    comp_type_t           comp_type;
    minmax_type_t         minmax_type;
    sign_mode_t           is_signed;
    logic [1:0]           wen;
    src_type_t            rs1_type;
    logic                 imm_op;
    logic                 sign_extend;
    logic                 single_bit_op;
    logic                 vd_widen;
    logic                 is_load;
    logic                 is_store;
    cfgsel_t              cfgsel;
    logic [REG_IDX_W-1:0] vs1;
    logic [REG_IDX_W-1:0] vs2;
    logic [REG_IDX_W-1:0] vd;
    logic [4:0]           imm_5;
  } vctrl_t;

endpackage

`default_nettype wire

//--- hw/vdec_fields_if.sv
// captured instruction fields from the field-capture stage to the decoder
`timescale 1ns/1ps
`default_nettype none

interface vdec_fields_if;
  import vdec_pkg::*;

  logic                 fields_valid;
  logic [6:0]           opcode;
  logic [2:0]           vfunct3;
  logic [5:0]           funct6;
  logic [REG_IDX_W-1:0] vs1;
  logic [REG_IDX_W-1:0] vs2;
  logic [REG_IDX_W-1:0] vd;
  logic [4:0]           imm_5;
  // instr[31:30], picks the config form
  logic [1:0]           cfg_hi;

  modport capture (output fields_valid, opcode, vfunct3, funct6, vs1, vs2, vd, imm_5, cfg_hi);
  modport decode (input fields_valid, opcode, vfunct3, funct6, vs1, vs2, vd, imm_5, cfg_hi);

endinterface

`default_nettype wire

//--- hw/vdec_op_if.sv
// decoded operation and class from the decoder to the control generator
`timescale 1ns/1ps
`default_nettype none

interface vdec_op_if;
  import vdec_pkg::*;

  logic                 op_valid;
  vop_t                 op;
  op_class_t            op_class;
  cfgsel_t              cfgsel;
  // set for the VECTOR opcode, legal or not
  logic                 is_vector;
  logic [2:0]           vfunct3;
  logic [REG_IDX_W-1:0] vs1;
  logic [REG_IDX_W-1:0] vs2;
  logic [REG_IDX_W-1:0] vd;
  logic [4:0]           imm_5;

  modport decode (output op_valid, op, op_class, cfgsel, is_vector, vfunct3, vs1, vs2, vd, imm_5);
  modport gen (input op_valid, op, op_class, cfgsel, is_vector, vfunct3, vs1, vs2, vd, imm_5);

endinterface

`default_nettype wire

//--- hw/vdec_field_capture.sv
// field capture: registers the incoming instruction and slices it into fields
`timescale 1ns/1ps
`default_nettype none

module vdec_field_capture (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         instr_valid,
  input  logic [vdec_pkg::INSTR_W-1:0] instr,
  vdec_fields_if.capture               fields
);
  import vdec_pkg::*;

  logic [INSTR_W-1:0] instr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fields.fields_valid <= 1'b0;
    end else begin
      fields.fields_valid <= instr_valid;
    end
  end

  // held between strobes
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      instr_q <= instr;
    end
  end

  assign fields.opcode  = instr_q[6:0];
  assign fields.vd      = instr_q[11:7];
  assign fields.vfunct3 = instr_q[14:12];
  assign fields.vs1     = instr_q[19:15];
  // same bits as vs1
  assign fields.imm_5   = instr_q[19:15];
  assign fields.vs2     = instr_q[24:20];
  assign fields.funct6  = instr_q[31:26];
  assign fields.cfg_hi  = instr_q[31:30];

endmodule

`default_nettype wire

//--- hw/vdec_op_decode.sv
// operation decoder: classifies the instruction and checks the funct3 form is allowed
`timescale 1ns/1ps
`default_nettype none

module vdec_op_decode (
  vdec_fields_if.decode fields,
  vdec_op_if.decode     op_out
);
  import vdec_pkg::*;

  logic is_vec;
  logic is_opi;
  logic is_opm;
  logic is_cfg;
  logic legal_width;
  logic vv_vx;
  logic vx_vi;
  vop_t opi_op;
  vop_t opm_op;
  vop_t op;

  assign is_vec = fields.opcode == VECTOR;
  assign is_opi = is_vec && (fields.vfunct3 == OPIVV || fields.vfunct3 == OPIVX ||
                             fields.vfunct3 == OPIVI);
  assign is_opm = is_vec && (fields.vfunct3 == OPMVV || fields.vfunct3 == OPMVX);
  assign is_cfg = is_vec && fields.vfunct3 == OPCFG;

  // load/store width sits in the funct3 slot
  assign legal_width = fields.vfunct3 == WIDTH8 || fields.vfunct3 == WIDTH16 ||
                       fields.vfunct3 == WIDTH32;

  assign vv_vx = fields.vfunct3 == OPIVV || fields.vfunct3 == OPIVX;
  assign vx_vi = fields.vfunct3 == OPIVX || fields.vfunct3 == OPIVI;

  always_comb begin
    case (fields.funct6)
      VADD:    opi_op = OP_VADD;
      VSUB:    opi_op = OP_VSUB;
      VRSUB:   opi_op = OP_VRSUB;
      VMINU:   opi_op = OP_VMINU;
      VMIN:    opi_op = OP_VMIN;
      VMAXU:   opi_op = OP_VMAXU;
      VMAX:    opi_op = OP_VMAX;
      VAND:    opi_op = OP_VAND;
      VOR:     opi_op = OP_VOR;
      VXOR:    opi_op = OP_VXOR;
      VMSEQ:   opi_op = OP_VMSEQ;
      VMSNE:   opi_op = OP_VMSNE;
      VMSLTU:  opi_op = OP_VMSLTU;
      VMSLT:   opi_op = OP_VMSLT;
      VMSLEU:  opi_op = OP_VMSLEU;
      VMSLE:   opi_op = OP_VMSLE;
      VMSGTU:  opi_op = OP_VMSGTU;
      VMSGT:   opi_op = OP_VMSGT;
      VSLL:    opi_op = OP_VSLL;
      VSRL:    opi_op = OP_VSRL;
      VSRA:    opi_op = OP_VSRA;
      default: opi_op = BAD_OP;
    endcase
  end

  always_comb begin
    case (fields.funct6)
      VDIVU:   opm_op = OP_VDIVU;
      VDIV:    opm_op = OP_VDIV;
      VREMU:   opm_op = OP_VREMU;
      VREM:    opm_op = OP_VREM;
      VMULHU:  opm_op = OP_VMULHU;
      VMUL:    opm_op = OP_VMUL;
      VMULHSU: opm_op = OP_VMULHSU;
      VMULH:   opm_op = OP_VMULH;
      VWADDU:  opm_op = OP_VWADDU;
      VWADD:   opm_op = OP_VWADD;
      VWSUBU:  opm_op = OP_VWSUBU;
      VWSUB:   opm_op = OP_VWSUB;
      default: opm_op = BAD_OP;
    endcase
  end

  // form check; every kept OPM op takes both MVV and MVX
  always_comb begin
    op = BAD_OP;
    if (is_opi) begin
      case (opi_op)
        OP_VSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX, OP_VMSLTU, OP_VMSLT:
          op = vv_vx ? opi_op : BAD_OP;
        OP_VRSUB, OP_VMSGTU, OP_VMSGT:
          op = vx_vi ? opi_op : BAD_OP;
        default:
          op = opi_op;
      endcase
    end else if (is_opm) begin
      op = opm_op;
    end
  end

  always_comb begin
    if (fields.opcode == LOAD_FP && legal_width) begin
      op_out.op_class = CLS_LOAD;
    end else if (fields.opcode == STORE_FP && legal_width) begin
      op_out.op_class = CLS_STORE;
    end else if (is_cfg) begin
      op_out.op_class = CLS_CFG;
    end else if (op != BAD_OP) begin
      op_out.op_class = CLS_ARITH;
    end else begin
      op_out.op_class = CLS_NONE;
    end
  end

  // bit31 low is vsetvli, then bit30 splits vsetivli from vsetvl
  always_comb begin
    if (!is_cfg) begin
      op_out.cfgsel = NOT_CFG;
    end else if (!fields.cfg_hi[1]) begin
      op_out.cfgsel = VSETVLI;
    end else if (fields.cfg_hi[0]) begin
      op_out.cfgsel = VSETIVLI;
    end else begin
      op_out.cfgsel = VSETVL;
    end
  end

  assign op_out.op_valid  = fields.fields_valid;
  assign op_out.op        = op;
  assign op_out.is_vector = is_vec;
  assign op_out.vfunct3   = fields.vfunct3;
  assign op_out.vs1       = fields.vs1;
  assign op_out.vs2       = fields.vs2;
  assign op_out.vd        = fields.vd;
  assign op_out.imm_5     = fields.imm_5;

endmodule

`default_nettype wire

//--- hw/vdec_ctrl_gen.sv
// control generator that maps the decoded operation to control fields and registers them
`timescale 1ns/1ps
`default_nettype none

module vdec_ctrl_gen (
  input  logic             clk,
  input  logic             rst_n,
  vdec_op_if.gen           op_in,
  output logic             ctrl_valid,
  output vdec_pkg::vctrl_t ctrl
);
  import vdec_pkg::*;

  vctrl_t ctrl_d;
  logic   is_ld;
  logic   is_st;
  logic   x_form;

  assign is_ld  = op_in.op_class == CLS_LOAD;
  assign is_st  = op_in.op_class == CLS_STORE;
  assign x_form = op_in.is_vector && (op_in.vfunct3 == OPIVX || op_in.vfunct3 == OPMVX);

  always_comb begin
    ctrl_d.illegal_insn  = op_in.op_class == CLS_NONE;
    ctrl_d.is_load       = is_ld;
    ctrl_d.is_store      = is_st;
    ctrl_d.cfgsel        = op_in.cfgsel;
    ctrl_d.wen           = (is_ld || op_in.op_class == CLS_ARITH) ? 2'b11 : 2'b00;
    ctrl_d.imm_op        = op_in.is_vector &&
                           (op_in.vfunct3 == OPIVI || op_in.vfunct3 == OPCFG);
    // shift amounts and the vsetivli AVL are zero-extended
    ctrl_d.sign_extend   = !(op_in.op inside {OP_VSLL, OP_VSRL, OP_VSRA} ||
                             op_in.cfgsel == VSETIVLI);
    ctrl_d.single_bit_op = op_in.op inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
                                            OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT};
    ctrl_d.vd_widen      = op_in.op inside {OP_VWADDU, OP_VWADD, OP_VWSUBU, OP_VWSUB};
    ctrl_d.vs1           = op_in.vs1;
    ctrl_d.vs2           = op_in.vs2;
    ctrl_d.vd            = op_in.vd;
    ctrl_d.imm_5         = op_in.imm_5;

    if (is_ld || is_st || x_form || op_in.cfgsel == VSETVLI || op_in.cfgsel == VSETVL) begin
      ctrl_d.rs1_type = X;
    end else if (ctrl_d.imm_op) begin
      ctrl_d.rs1_type = I;
    end else begin
      ctrl_d.rs1_type = V;
    end

    if (is_ld) begin
      ctrl_d.fu_type = LOAD_UNIT;
    end else if (is_st) begin
      ctrl_d.fu_type = STORE_UNIT;
    end else if (op_in.op inside {OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU}) begin
      ctrl_d.fu_type = MUL;
    end else if (op_in.op inside {OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM}) begin
      ctrl_d.fu_type = DIV;
    end else begin
      ctrl_d.fu_type = ARITH;
    end

    case (op_in.op)
      OP_VSRL:                                ctrl_d.alu_op = SRL;
      OP_VSRA:                                ctrl_d.alu_op = SRA;
      OP_VADD, OP_VWADDU, OP_VWADD:           ctrl_d.alu_op = ADD;
      OP_VSUB, OP_VRSUB, OP_VWSUBU, OP_VWSUB: ctrl_d.alu_op = SUB;
      OP_VAND:                                ctrl_d.alu_op = AND;
      OP_VOR:                                 ctrl_d.alu_op = OR;
      OP_VXOR:                                ctrl_d.alu_op = XOR;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX:   ctrl_d.alu_op = MM;
      default: ctrl_d.alu_op = ctrl_d.single_bit_op ? COMP : SLL;
    endcase

    case (op_in.op)
      OP_VMSNE:  ctrl_d.comp_type = VSNE;
      OP_VMSLTU: ctrl_d.comp_type = VSLTU;
      OP_VMSLT:  ctrl_d.comp_type = VSLT;
      OP_VMSLEU: ctrl_d.comp_type = VSLEU;
      OP_VMSLE:  ctrl_d.comp_type = VSLE;
      OP_VMSGTU: ctrl_d.comp_type = VSGTU;
      OP_VMSGT:  ctrl_d.comp_type = VSGT;
      default:   ctrl_d.comp_type = VSEQ;
    endcase

    case (op_in.op)
      OP_VMINU: ctrl_d.minmax_type = MINU;
      OP_VMAX:  ctrl_d.minmax_type = MAX;
      OP_VMAXU: ctrl_d.minmax_type = MAXU;
      default:  ctrl_d.minmax_type = MIN;
    endcase

    // mulhsu takes vs2 signed and vs1 unsigned
    case (op_in.op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ, OP_VMSNE, OP_VMSLT, OP_VMSLE,
      OP_VMSGT, OP_VMUL, OP_VMULH, OP_VDIV, OP_VREM, OP_VWADD, OP_VWSUB:
        ctrl_d.is_signed = SIGNED;
      OP_VMULHSU:
        ctrl_d.is_signed = UNSIGNED_SIGNED;
      default:
        ctrl_d.is_signed = UNSIGNED;
    endcase
  end

  // fields hold on invalid cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_valid <= 1'b0;
      ctrl       <= '0;
    end else begin
      ctrl_valid <= op_in.op_valid;
      if (op_in.op_valid) begin
        ctrl <= ctrl_d;
      end
    end
  end

  // only the arithmetic class carries a real operation
  a_arith_has_op: assert property (@(posedge clk) disable iff (!rst_n)
    op_in.op_valid |-> ((op_in.op_class == CLS_ARITH) == (op_in.op != BAD_OP)));

  // an illegal instruction never writes the register file
  a_illegal_no_wen: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.illegal_insn |-> ctrl.wen == 2'b00);

endmodule

`default_nettype wire

//--- hw/vector_decode_unit.sv
// vector decode unit: capture, decode and control stages, two cycles from instruction to control
`timescale 1ns/1ps
`default_nettype none

module vector_decode_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           instr_valid,
  input  logic [vdec_pkg::INSTR_W-1:0]   instr,
  output logic                           ctrl_valid,
  output logic                           illegal_insn,
  output vdec_pkg::fu_type_t             fu_type,
  output vdec_pkg::valu_op_t             alu_op,
  output vdec_pkg::comp_type_t           comp_type,
  output vdec_pkg::minmax_type_t         minmax_type,
  output vdec_pkg::sign_mode_t           is_signed,
  output logic [1:0]                     wen,
  output vdec_pkg::src_type_t            rs1_type,
  output logic                           imm_op,
  output logic                           sign_extend,
  output logic                           single_bit_op,
  output logic                           vd_widen,
  output logic                           is_load,
  output logic                           is_store,
  output vdec_pkg::cfgsel_t              cfgsel,
  output logic [vdec_pkg::REG_IDX_W-1:0] vs1,
  output logic [vdec_pkg::REG_IDX_W-1:0] vs2,
  output logic [vdec_pkg::REG_IDX_W-1:0] vd,
  output logic [4:0]                     imm_5
);
  import vdec_pkg::*;

  vctrl_t ctrl_q;

  vdec_fields_if fields_bus ();
  vdec_op_if     op_bus ();

  vdec_field_capture u_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .fields      (fields_bus.capture)
  );

  vdec_op_decode u_decode (
    .fields (fields_bus.decode),
    .op_out (op_bus.decode)
  );

  vdec_ctrl_gen u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_in      (op_bus.gen),
    .ctrl_valid (ctrl_valid),
    .ctrl       (ctrl_q)
  );

  assign illegal_insn  = ctrl_q.illegal_insn;
  assign fu_type       = ctrl_q.fu_type;
  assign alu_op        = ctrl_q.alu_op;
  assign comp_type     = ctrl_q.comp_type;
  assign minmax_type   = ctrl_q.minmax_type;
  assign is_signed     = ctrl_q.is_signed;
  assign wen           = ctrl_q.wen;
  assign rs1_type      = ctrl_q.rs1_type;
  assign imm_op        = ctrl_q.imm_op;
  assign sign_extend   = ctrl_q.sign_extend;
  assign single_bit_op = ctrl_q.single_bit_op;
  assign vd_widen      = ctrl_q.vd_widen;
  assign is_load       = ctrl_q.is_load;
  assign is_store      = ctrl_q.is_store;
  assign cfgsel        = ctrl_q.cfgsel;
  assign vs1           = ctrl_q.vs1;
  assign vs2           = ctrl_q.vs2;
  assign vd            = ctrl_q.vd;
  assign imm_5         = ctrl_q.imm_5;

endmodule

`default_nettype wire

//--- testbench/tb_vector_decode_unit.sv
// vector decode unit testbench with LFSR and directed stimulus, reference model and assertions
`timescale 1ns/1ps
`default_nettype none

module tb_vector_decode_unit;
  import vdec_pkg::*;

  // allowed funct3 forms with one bit per funct3 value
  localparam logic [7:0] FORMS_ALL   = 8'b0001_1001;
  localparam logic [7:0] FORMS_VV_VX = 8'b0001_0001;
  localparam logic [7:0] FORMS_VX_VI = 8'b0001_1000;
  localparam logic [7:0] FORMS_OPM   = 8'b0100_0100;

  typedef struct packed {
    logic [7:0]   forms;
    fu_type_t     fu;
    valu_op_t     alu;
    comp_type_t   cmp;
    minmax_type_t mm;
    sign_mode_t   sgn;
    logic         widen;
  } op_row_t;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  logic [INSTR_W-1:0]   instr;
  logic                 ctrl_valid;
  logic                 illegal_insn;
  fu_type_t             fu_type;
  valu_op_t             alu_op;
  comp_type_t           comp_type;
  minmax_type_t         minmax_type;
  sign_mode_t           is_signed;
  logic [1:0]           wen;
  src_type_t            rs1_type;
  logic                 imm_op;
  logic                 sign_extend;
  logic                 single_bit_op;
  logic                 vd_widen;
  logic                 is_load;
  logic                 is_store;
  cfgsel_t              cfgsel;
  logic [REG_IDX_W-1:0] vs1;
  logic [REG_IDX_W-1:0] vs2;
  logic [REG_IDX_W-1:0] vd;
  logic [4:0]           imm_5;

  vctrl_t      got;
  vctrl_t      exp_head;
  vctrl_t      exp_q[$];
  int          pending;
  logic [31:0] lfsr;
  int          value_errors;
  int          flow_errors;
  int          timeouts;

  vector_decode_unit dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .ctrl_valid    (ctrl_valid),
    .illegal_insn  (illegal_insn),
    .fu_type       (fu_type),
    .alu_op        (alu_op),
    .comp_type     (comp_type),
    .minmax_type   (minmax_type),
    .is_signed     (is_signed),
    .wen           (wen),
    .rs1_type      (rs1_type),
    .imm_op        (imm_op),
    .sign_extend   (sign_extend),
    .single_bit_op (single_bit_op),
    .vd_widen      (vd_widen),
    .is_load       (is_load),
    .is_store      (is_store),
    .cfgsel        (cfgsel),
    .vs1           (vs1),
    .vs2           (vs2),
    .vd            (vd),
    .imm_5         (imm_5)
  );

  assign got = {illegal_insn, fu_type, alu_op, comp_type, minmax_type, is_signed, wen,
                rs1_type, imm_op, sign_extend, single_bit_op, vd_widen, is_load, is_store,
                cfgsel, vs1, vs2, vd, imm_5};

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic op_row_t opi_row(input logic [5:0] f6);
    op_row_t r;
    case (f6)
      VADD:    r = '{FORMS_ALL, ARITH, ADD, VSEQ, MIN, SIGNED, 1'b0};
      VSUB:    r = '{FORMS_VV_VX, ARITH, SUB, VSEQ, MIN, SIGNED, 1'b0};
      VRSUB:   r = '{FORMS_VX_VI, ARITH, SUB, VSEQ, MIN, SIGNED, 1'b0};
      VMINU:   r = '{FORMS_VV_VX, ARITH, MM, VSEQ, MINU, UNSIGNED, 1'b0};
      VMIN:    r = '{FORMS_VV_VX, ARITH, MM, VSEQ, MIN, SIGNED, 1'b0};
      VMAXU:   r = '{FORMS_VV_VX, ARITH, MM, VSEQ, MAXU, UNSIGNED, 1'b0};
      VMAX:    r = '{FORMS_VV_VX, ARITH, MM, VSEQ, MAX, SIGNED, 1'b0};
      VAND:    r = '{FORMS_ALL, ARITH, AND, VSEQ, MIN, UNSIGNED, 1'b0};
      VOR:     r = '{FORMS_ALL, ARITH, OR, VSEQ, MIN, UNSIGNED, 1'b0};
      VXOR:    r = '{FORMS_ALL, ARITH, XOR, VSEQ, MIN, UNSIGNED, 1'b0};
      VMSEQ:   r = '{FORMS_ALL, ARITH, COMP, VSEQ, MIN, SIGNED, 1'b0};
      VMSNE:   r = '{FORMS_ALL, ARITH, COMP, VSNE, MIN, SIGNED, 1'b0};
      VMSLTU:  r = '{FORMS_VV_VX, ARITH, COMP, VSLTU, MIN, UNSIGNED, 1'b0};
      VMSLT:   r = '{FORMS_VV_VX, ARITH, COMP, VSLT, MIN, SIGNED, 1'b0};
      VMSLEU:  r = '{FORMS_ALL, ARITH, COMP, VSLEU, MIN, UNSIGNED, 1'b0};
      VMSLE:   r = '{FORMS_ALL, ARITH, COMP, VSLE, MIN, SIGNED, 1'b0};
      VMSGTU:  r = '{FORMS_VX_VI, ARITH, COMP, VSGTU, MIN, UNSIGNED, 1'b0};
      VMSGT:   r = '{FORMS_VX_VI, ARITH, COMP, VSGT, MIN, SIGNED, 1'b0};
      VSLL:    r = '{FORMS_ALL, ARITH, SLL, VSEQ, MIN, UNSIGNED, 1'b0};
      VSRL:    r = '{FORMS_ALL, ARITH, SRL, VSEQ, MIN, UNSIGNED, 1'b0};
      VSRA:    r = '{FORMS_ALL, ARITH, SRA, VSEQ, MIN, UNSIGNED, 1'b0};
      default: r = '{8'h00, ARITH, SLL, VSEQ, MIN, UNSIGNED, 1'b0};
    endcase
    return r;
  endfunction

  function automatic op_row_t opm_row(input logic [5:0] f6);
    op_row_t r;
    case (f6)
      VDIVU:   r = '{FORMS_OPM, DIV, SLL, VSEQ, MIN, UNSIGNED, 1'b0};
      VDIV:    r = '{FORMS_OPM, DIV, SLL, VSEQ, MIN, SIGNED, 1'b0};
      VREMU:   r = '{FORMS_OPM, DIV, SLL, VSEQ, MIN, UNSIGNED, 1'b0};
      VREM:    r = '{FORMS_OPM, DIV, SLL, VSEQ, MIN, SIGNED, 1'b0};
      VMULHU:  r = '{FORMS_OPM, MUL, SLL, VSEQ, MIN, UNSIGNED, 1'b0};
      VMUL:    r = '{FORMS_OPM, MUL, SLL, VSEQ, MIN, SIGNED, 1'b0};
      VMULHSU: r = '{FORMS_OPM, MUL, SLL, VSEQ, MIN, UNSIGNED_SIGNED, 1'b0};
      VMULH:   r = '{FORMS_OPM, MUL, SLL, VSEQ, MIN, SIGNED, 1'b0};
      VWADDU:  r = '{FORMS_OPM, ARITH, ADD, VSEQ, MIN, UNSIGNED, 1'b1};
      VWADD:   r = '{FORMS_OPM, ARITH, ADD, VSEQ, MIN, SIGNED, 1'b1};
      VWSUBU:  r = '{FORMS_OPM, ARITH, SUB, VSEQ, MIN, UNSIGNED, 1'b1};
      VWSUB:   r = '{FORMS_OPM, ARITH, SUB, VSEQ, MIN, SIGNED, 1'b1};
      default: r = '{8'h00, ARITH, SLL, VSEQ, MIN, UNSIGNED, 1'b0};
    endcase
    return r;
  endfunction

  // expected control for one instruction with zero wherever no rule applies
  function automatic vctrl_t model_ctrl(input logic [31:0] ins);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       vec;
    logic       width_ok;
    logic       arith;
    op_row_t    r;
    vctrl_t     e;
    opc      = ins[6:0];
    f3       = ins[14:12];
    vec      = opc == VECTOR;
    width_ok = f3 == WIDTH8 || f3 == WIDTH16 || f3 == WIDTH32;
    if (f3 == OPMVV || f3 == OPMVX) begin
      r = opm_row(ins[31:26]);
    end else begin
      r = opi_row(ins[31:26]);
    end
    arith      = vec && r.forms[f3];
    e          = '0;
    e.vd       = ins[11:7];
    e.vs1      = ins[19:15];
    e.imm_5    = ins[19:15];
    e.vs2      = ins[24:20];
    e.is_load  = opc == LOAD_FP && width_ok;
    e.is_store = opc == STORE_FP && width_ok;
    if (vec && f3 == OPCFG && !ins[31]) begin
      e.cfgsel = VSETVLI;
    end else if (vec && f3 == OPCFG) begin
      e.cfgsel = ins[30] ? VSETIVLI : VSETVL;
    end
    e.illegal_insn = !(e.is_load || e.is_store || e.cfgsel != NOT_CFG || arith);
    e.wen          = (e.is_load || arith) ? 2'b11 : 2'b00;
    e.imm_op       = vec && (f3 == OPIVI || f3 == OPCFG);
    e.sign_extend  = e.cfgsel != VSETIVLI;
    if (e.is_load || e.is_store || e.cfgsel inside {VSETVLI, VSETVL} ||
        (vec && (f3 == OPIVX || f3 == OPMVX))) begin
      e.rs1_type = X;
    end else if (e.imm_op) begin
      e.rs1_type = I;
    end
    if (e.is_load) begin
      e.fu_type = LOAD_UNIT;
    end else if (e.is_store) begin
      e.fu_type = STORE_UNIT;
    end
    if (arith) begin
      e.fu_type       = r.fu;
      e.alu_op        = r.alu;
      e.comp_type     = r.cmp;
      e.minmax_type   = r.mm;
      e.is_signed     = r.sgn;
      e.single_bit_op = r.alu == COMP;
      e.vd_widen      = r.widen;
      // shift amounts are zero-extended
      if (r.fu == ARITH && r.alu inside {SLL, SRL, SRA}) begin
        e.sign_extend = 1'b0;
      end
    end
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got_v,
                               input logic [31:0] exp_v);
    if (got_v !== exp_v) begin
      value_errors++;
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got_v, exp_v);
    end
  endtask

  task automatic report_field_diffs(input vctrl_t g, input vctrl_t e);
    compare_field("illegal_insn", g.illegal_insn, e.illegal_insn);
    compare_field("fu_type", g.fu_type, e.fu_type);
    compare_field("alu_op", g.alu_op, e.alu_op);
    compare_field("comp_type", g.comp_type, e.comp_type);
    compare_field("minmax_type", g.minmax_type, e.minmax_type);
    compare_field("is_signed", g.is_signed, e.is_signed);
    compare_field("wen", g.wen, e.wen);
    compare_field("rs1_type", g.rs1_type, e.rs1_type);
    compare_field("imm_op", g.imm_op, e.imm_op);
    compare_field("sign_extend", g.sign_extend, e.sign_extend);
    compare_field("single_bit_op", g.single_bit_op, e.single_bit_op);
    compare_field("vd_widen", g.vd_widen, e.vd_widen);
    compare_field("is_load", g.is_load, e.is_load);
    compare_field("is_store", g.is_store, e.is_store);
    compare_field("cfgsel", g.cfgsel, e.cfgsel);
    compare_field("vs1", g.vs1, e.vs1);
    compare_field("vs2", g.vs2, e.vs2);
    compare_field("vd", g.vd, e.vd);
    compare_field("imm_5", g.imm_5, e.imm_5);
  endtask

  task automatic drive(input logic v, input logic [31:0] ins);
    @(posedge clk);
    #1;
    instr_valid = v;
    instr       = ins;
  endtask

  // expected control is pushed when an instruction is taken and popped when it comes out
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_q.delete();
    end else begin
      if (ctrl_valid && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (instr_valid) begin
        exp_q.push_back(model_ctrl(instr));
      end
    end
    exp_head <= exp_q.size() > 0 ? exp_q[0] : '0;
    pending  <= exp_q.size();
  end

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid == $past(instr_valid, 2))
    else begin
      flow_errors++;
      $display("** Error at %0t ns: ctrl_valid = %0b, expected %0b", $time,
               $sampled(ctrl_valid), !$sampled(ctrl_valid));
    end

  a_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> pending > 0)
    else begin
      flow_errors++;
      $display("control came out at %0t ns with no instruction in flight", $time);
    end

  a_ctrl_match: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> got == exp_head)
    else report_field_diffs($sampled(got), $sampled(exp_head));

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !ctrl_valid |-> $stable(got))
    else begin
      flow_errors++;
      $display("control outputs changed at %0t ns while ctrl_valid was low", $time);
    end

  initial begin
    logic [31:0] hi;
    logic [31:0] lo;
    logic [6:0]  opc;
    logic        v;
    int          wait_n;
    lfsr         = 32'h9fb2;
    value_errors = 0;
    flow_errors  = 0;
    timeouts     = 0;
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // ctrl_valid must stay low while idle
    repeat (4) drive(1'b0, '0);

    // every funct6 with every funct3 on the VECTOR opcode back to back
    for (int f6 = 0; f6 < 64; f6++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        hi = take_bits(11);
        lo = take_bits(5);
        drive(1'b1, {6'(f6), hi[10:0], 3'(f3), lo[4:0], VECTOR});
      end
    end

    // loads and stores over all widths
    for (int st = 0; st < 2; st++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        repeat (3) begin
          hi  = take_bits(17);
          lo  = take_bits(5);
          opc = (st == 1) ? STORE_FP : LOAD_FP;
          drive(1'b1, {hi[16:0], 3'(f3), lo[4:0], opc});
        end
      end
    end

    // random opcodes and fields with gaps in instr_valid
    repeat (600) begin
      case (2'(take_bits(2)))
        2'd0:    opc = LOAD_FP;
        2'd1:    opc = STORE_FP;
        2'd2:    opc = VECTOR;
        default: opc = 7'(take_bits(7));
      endcase
      v  = 2'(take_bits(2)) != 2'd0;
      hi = take_bits(25);
      drive(v, {hi[24:0], opc});
    end
    drive(1'b0, '0);

    wait_n = 0;
    while (pending != 0 && wait_n < 10) begin
      @(posedge clk);
      wait_n++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("timeout: %0d decoded instructions never came out", pending);
    end
    repeat (2) @(posedge clk);

    $display("value errors: %0d, flow errors: %0d, timeouts: %0d",
             value_errors, flow_errors, timeouts);
    if (value_errors + flow_errors + timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/vdec_pkg.sv
hw/vdec_fields_if.sv
hw/vdec_op_if.sv
hw/vdec_field_capture.sv
hw/vdec_op_decode.sv
hw/vdec_ctrl_gen.sv
hw/vector_decode_unit.sv
testbench/tb_vector_decode_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vector_decode_unit
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx 'Finished with errors' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qx 'Finished with no errors' $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
